/* rtl/xbus_pkg.sv */
// Bus address map and constants
`default_nettype none

package xbus_pkg;

   localparam int addr_width = 22;
   localparam int data_width = 32;

   // Main memory.
   localparam int ram_words = 4096;
   localparam int ram_index_width = $clog2(ram_words);
   localparam logic [addr_width-1:0] ram_decode_limit = 22'o11000000;
   localparam int ram_ack_stages = 7;

   // Device register block.
   localparam logic [addr_width-1:0] io_base = 22'o17773000;
   localparam int io_regs = 8;
   localparam int io_sel_width = $clog2(io_regs);

   localparam int no_response_cycles = 32;
   localparam int timer_width = $clog2(no_response_cycles + 1);

   localparam logic [data_width-1:0] error_data = '1;

   // Controller state encoding.
   localparam int state_width = 3;
   localparam logic [state_width-1:0] state_idle = 3'd0;
   localparam logic [state_width-1:0] state_request = 3'd1;
   localparam logic [state_width-1:0] state_wait_ack = 3'd2;
   localparam logic [state_width-1:0] state_wait_timer = 3'd3;
   localparam logic [state_width-1:0] state_finish = 3'd4;

endpackage

`default_nettype wire

/* rtl/xbus_ctrl.sv */
// Bus transfer controller
`timescale 1ns/1ps
`default_nettype none

module xbus_ctrl
   import xbus_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  start,
   input  wire logic [addr_width-1:0] addr,
   input  wire logic [data_width-1:0] wdata,
   input  wire logic                  write,
   input  wire logic                  ram_decode,
   input  wire logic                  ram_ack,
   input  wire logic [data_width-1:0] ram_rdata,
   input  wire logic                  io_decode,
   input  wire logic                  io_ack,
   input  wire logic [data_width-1:0] io_rdata,
   input  wire logic                  expired,
   output logic                       busy,
   output logic                       done,
   output logic [data_width-1:0]      rdata,
   output logic                       bus_error,
   output logic                       bus_req,
   output logic                       bus_write,
   output logic [addr_width-1:0]      bus_addr,
   output logic [data_width-1:0]      bus_wdata,
   output logic                       timer_start
);

   logic [state_width-1:0] state;
   logic                   sel_ram;
   logic                   slave_ack;

   assign busy = state != state_idle;
   assign done = state == state_finish;
   assign slave_ack = sel_ram ? ram_ack : io_ack;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= state_idle;
         bus_req <= 1'b0;
         timer_start <= 1'b0;
      end
      else
      begin
         timer_start <= 1'b0;
         case (state)
            state_idle:
               if (start)
               begin
                  state <= state_request;
                  bus_req <= 1'b1;
               end
            state_request:
               if (ram_decode || io_decode)
                  state <= state_wait_ack;
               else
               begin
                  state <= state_wait_timer;
                  timer_start <= 1'b1;        // Nobody home.
               end
            state_wait_ack:
               if (slave_ack)
               begin
                  state <= state_finish;
                  bus_req <= 1'b0;
               end
            state_wait_timer:
               if (expired)
               begin
                  state <= state_finish;
                  bus_req <= 1'b0;
               end
            state_finish:
               state <= state_idle;
            default:
               state <= state_idle;
         endcase
      end
   end

   // Transfer payload and result.
   always_ff @(posedge clk)
   begin
      if (state == state_idle && start)
      begin
         bus_addr <= addr;
         bus_wdata <= wdata;
         bus_write <= write;
      end
      if (state == state_request)
         sel_ram <= ram_decode;
      if (state == state_wait_ack && slave_ack)
      begin
         rdata <= sel_ram ? ram_rdata : io_rdata;
         bus_error <= 1'b0;
      end
      if (state == state_wait_timer && expired)
      begin
         rdata <= error_data;
         bus_error <= 1'b1;
      end
   end

   a_req_held: assert property (@(posedge clk) disable iff (reset)
      $fell(bus_req) |-> $past(ram_ack || io_ack || expired || reset));

   a_one_ack: assert property (@(posedge clk) disable iff (reset)
      !(ram_ack && io_ack));

endmodule

`default_nettype wire

/* rtl/xbus_timer.sv */
// No-response timer
`timescale 1ns/1ps
`default_nettype none

module xbus_timer
   import xbus_pkg::*;
(
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic timer_start,
   output logic      expired
);

   logic [timer_width-1:0] count;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= '0;
         expired <= 1'b0;
      end
      else
      begin
         expired <= 1'b0;
         if (timer_start)
            count <= timer_width'(no_response_cycles - 1);    // Strobe cycle counts as one.
         else if (count != '0)
         begin
            count <= count - 1'b1;
            expired <= count == timer_width'(1);    // Last tick.
         end
      end
   end

   // The controller only starts the timer when it is idle.
   a_no_restart: assert property (@(posedge clk) disable iff (reset)
      timer_start |-> count == '0);

endmodule

`default_nettype wire

/* rtl/xbus_ram.sv */
// Main memory slave
`timescale 1ns/1ps
`default_nettype none

module xbus_ram
   import xbus_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic [addr_width-1:0] bus_addr,
   input  wire logic [data_width-1:0] bus_wdata,
   input  wire logic                  bus_req,
   input  wire logic                  bus_write,
   output logic [data_width-1:0]      ram_rdata,
   output logic                       ram_ack,
   output logic                       ram_decode
);

   logic [data_width-1:0]      mem [0:ram_words-1];
   logic                       req_delayed;
   logic [ram_ack_stages-1:0]  ack_delayed;
   logic                       backed;
   logic [ram_index_width-1:0] index;

   initial
   begin
      for (int i = 0; i < ram_words; i++)
         mem[i] = '0;
   end

   // Decoded region extends past the backed words.
   assign ram_decode = bus_addr < ram_decode_limit;
   assign backed = bus_addr < addr_width'(ram_words);
   assign index = bus_addr[ram_index_width-1:0];
   assign ram_ack = ack_delayed[ram_ack_stages-1];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_delayed <= 1'b0;
         ack_delayed <= '0;
      end
      else
      begin
         req_delayed <= bus_req && ram_decode && !req_delayed && ack_delayed == '0;
         ack_delayed <= {ack_delayed[ram_ack_stages-2:0], req_delayed};
      end
   end

   // Write lands on the edge that raises ack.
   always_ff @(posedge clk)
   begin
      if (bus_req && bus_write && backed && ack_delayed[ram_ack_stages-2])
         mem[index] <= bus_wdata;
   end

   assign ram_rdata = backed ? mem[index] : error_data;    // Tail reads all ones.

   a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
      ram_ack |=> !ram_ack);

endmodule

`default_nettype wire

/* rtl/xbus_io.sv */
// Device register slave
`timescale 1ns/1ps
`default_nettype none

module xbus_io
   import xbus_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic [addr_width-1:0] bus_addr,
   input  wire logic [data_width-1:0] bus_wdata,
   input  wire logic                  bus_req,
   input  wire logic                  bus_write,
   output logic [data_width-1:0]      io_rdata,
   output logic                       io_ack,
   output logic                       io_decode
);

   logic [data_width-1:0]   regs [0:io_regs-1];
   logic [io_sel_width-1:0] sel;
   logic                    hit;

   // Block is aligned, so the upper bits alone decode it.
   assign io_decode = bus_addr[addr_width-1:io_sel_width] ==
                      io_base[addr_width-1:io_sel_width];
   assign sel = bus_addr[io_sel_width-1:0];
   assign hit = bus_req && io_decode && !io_ack;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         io_ack <= 1'b0;
         for (int i = 0; i < io_regs; i++)
            regs[i] <= '0;
      end
      else
      begin
         io_ack <= hit;
         if (hit && bus_write)
            regs[sel] <= bus_wdata;
      end
   end

   assign io_rdata = regs[sel];

   // Controller keeps the request up until it sees our ack.
   a_req_during_ack: assert property (@(posedge clk) disable iff (reset)
      io_ack |-> bus_req);

endmodule

`default_nettype wire

/* rtl/xbus_top.sv */
// Bus subsystem top level
`timescale 1ns/1ps
`default_nettype none

module xbus_top
   import xbus_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  start,
   input  wire logic [addr_width-1:0] addr,
   input  wire logic [data_width-1:0] wdata,
   input  wire logic                  write,
   output logic                       busy,
   output logic                       done,
   output logic [data_width-1:0]      rdata,
   output logic                       bus_error
);

   logic                  bus_req;
   logic                  bus_write;
   logic [addr_width-1:0] bus_addr;
   logic [data_width-1:0] bus_wdata;
   logic                  ram_decode;
   logic                  ram_ack;
   logic [data_width-1:0] ram_rdata;
   logic                  io_decode;
   logic                  io_ack;
   logic [data_width-1:0] io_rdata;
   logic                  timer_start;
   logic                  expired;

   xbus_ctrl u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .addr        (addr),
      .wdata       (wdata),
      .write       (write),
      .ram_decode  (ram_decode),
      .ram_ack     (ram_ack),
      .ram_rdata   (ram_rdata),
      .io_decode   (io_decode),
      .io_ack      (io_ack),
      .io_rdata    (io_rdata),
      .expired     (expired),
      .busy        (busy),
      .done        (done),
      .rdata       (rdata),
      .bus_error   (bus_error),
      .bus_req     (bus_req),
      .bus_write   (bus_write),
      .bus_addr    (bus_addr),
      .bus_wdata   (bus_wdata),
      .timer_start (timer_start)
   );

   xbus_timer u_timer (
      .clk         (clk),
      .reset       (reset),
      .timer_start (timer_start),
      .expired     (expired)
   );

   xbus_ram u_ram (
      .clk        (clk),
      .reset      (reset),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_req    (bus_req),
      .bus_write  (bus_write),
      .ram_rdata  (ram_rdata),
      .ram_ack    (ram_ack),
      .ram_decode (ram_decode)
   );

   xbus_io u_io (
      .clk       (clk),
      .reset     (reset),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_req   (bus_req),
      .bus_write (bus_write),
      .io_rdata  (io_rdata),
      .io_ack    (io_ack),
      .io_decode (io_decode)
   );

endmodule

`default_nettype wire

/* verif/xbus_checker.sv */
// Bus transfer checker
`timescale 1ns/1ps
`default_nettype none

module xbus_checker
   import xbus_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  start,
   input  wire logic [addr_width-1:0] addr,
   input  wire logic [data_width-1:0] wdata,
   input  wire logic                  write,
   input  wire logic                  busy,
   input  wire logic                  done,
   input  wire logic [data_width-1:0] rdata,
   input  wire logic                  bus_error,
   input  wire logic [31:0]           test_num,
   input  wire logic                  test_end,
   output int                         error_count,
   output int                         failed_tests
);

   logic [data_width-1:0] mem_model [0:ram_words-1];
   logic [data_width-1:0] io_model [0:io_regs-1];
   logic                  outstanding = 1'b0;
   logic                  was_outstanding;
   logic [addr_width-1:0] exp_addr = '0;
   logic [data_width-1:0] exp_rdata;
   logic                  exp_error;
   logic                  exp_has_rdata;
   int                    exp_latency;
   int                    latency = 0;
   int                    test_errors = 0;

   initial
   begin
      error_count = 0;
      failed_tests = 0;
      for (int i = 0; i < ram_words; i++)
         mem_model[i] = '0;
   end

   function automatic string test_name(input logic [31:0] n);
      case (n)
         1: return "backed_memory";
         2: return "unbacked_tail";
         3: return "device_regs";
         4: return "undecoded";
         5: return "dropped_start";
         6: return "mixed_random";
         default: return "no_test";
      endcase
   endfunction

   task automatic mismatch(input string what, input logic [data_width-1:0] expected,
                           input logic [data_width-1:0] actual);
      $display("MISMATCH %s %s at %o: expected %h actual %h",
               test_name(test_num), what, exp_addr, expected, actual);
      error_count++;
      test_errors++;
   endtask

   task automatic fault(input string msg);
      $display("ERROR %s: %s", test_name(test_num), msg);
      error_count++;
      test_errors++;
   endtask

   // Predicts the result from the address map and updates the model.
   task automatic predict();
      exp_addr = addr;
      exp_error = 1'b0;
      exp_has_rdata = !write;
      exp_latency = ram_ack_stages + 3;
      if (addr < addr_width'(ram_words))
      begin
         exp_rdata = mem_model[int'(addr)];
         if (write)
            mem_model[int'(addr)] = wdata;
      end
      else if (addr < ram_decode_limit)
         exp_rdata = error_data;                 // Decoded but unbacked.
      else if (addr >= io_base && addr < io_base + addr_width'(io_regs))
      begin
         exp_latency = 3;
         exp_rdata = io_model[int'(addr - io_base)];
         if (write)
            io_model[int'(addr - io_base)] = wdata;
      end
      else
      begin
         exp_latency = no_response_cycles + 3;
         exp_rdata = error_data;
         exp_error = 1'b1;
         exp_has_rdata = 1'b1;                   // Error data on writes too.
      end
   endtask

   always @(posedge clk)
   begin
      if (reset)
      begin
         outstanding = 1'b0;
         for (int i = 0; i < io_regs; i++)
            io_model[i] = '0;
      end
      else
      begin
         was_outstanding = outstanding;
         if (was_outstanding)
            latency++;
         if (busy !== was_outstanding)
            mismatch("busy", data_width'(was_outstanding), data_width'(busy));
         if (done)
         begin
            if (!was_outstanding)
               fault("done strobe with no transfer outstanding");
            else
            begin
               if (latency != exp_latency)
                  mismatch("latency", data_width'(exp_latency), data_width'(latency));
               if (bus_error !== exp_error)
                  mismatch("bus_error", data_width'(exp_error), data_width'(bus_error));
               if (exp_has_rdata && rdata !== exp_rdata)
                  mismatch("rdata", exp_rdata, rdata);
            end
            outstanding = 1'b0;
         end
         if (start && !was_outstanding)
         begin
            predict();
            latency = 0;
            outstanding = 1'b1;
         end
         if (test_end)
         begin
            if (outstanding)
               fault("transfer still outstanding at end of test");
            $display("test %0d %s: %s, %0d errors", test_num, test_name(test_num),
                     test_errors == 0 ? "ok" : "failed", test_errors);
            if (test_errors != 0)
               failed_tests++;
            test_errors = 0;
         end
      end
   end

endmodule

`default_nettype wire

/* verif/xbus_tb.sv */
// Bus subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module xbus_tb
   import xbus_pkg::*;
();

   localparam int n_tests = 6;
   localparam int n_backed = 32;
   localparam int n_tail = 8;
   localparam int n_undecoded = 12;
   localparam int n_dropped = 10;
   localparam int n_mixed = 100;
   localparam int total_transfers = 2 * n_backed + 3 * n_tail + 4 * io_regs
                                    + n_undecoded + n_dropped + n_mixed;
   localparam int cycle_limit = total_transfers * (no_response_cycles + 10) + 100;

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  start;
   logic [addr_width-1:0] addr;
   logic [data_width-1:0] wdata;
   logic                  write;
   logic                  busy;
   logic                  done;
   logic [data_width-1:0] rdata;
   logic                  bus_error;
   logic [31:0]           test_num;
   logic                  test_end;
   logic [addr_width-1:0] saved [0:n_backed-1];
   int                    cycles = 0;
   int                    error_count;
   int                    failed_tests;

   always #5 clk = ~clk;

   xbus_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .addr      (addr),
      .wdata     (wdata),
      .write     (write),
      .busy      (busy),
      .done      (done),
      .rdata     (rdata),
      .bus_error (bus_error)
   );

   xbus_checker u_checker (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .addr         (addr),
      .wdata        (wdata),
      .write        (write),
      .busy         (busy),
      .done         (done),
      .rdata        (rdata),
      .bus_error    (bus_error),
      .test_num     (test_num),
      .test_end     (test_end),
      .error_count  (error_count),
      .failed_tests (failed_tests)
   );

   function automatic logic [addr_width-1:0] backed_addr();
      return addr_width'($urandom % ram_words);
   endfunction

   function automatic logic [addr_width-1:0] tail_addr();
      return addr_width'(ram_words) +
             addr_width'($urandom % (int'(ram_decode_limit) - ram_words));
   endfunction

   // Tail address with the same low bits as a backed word.
   function automatic logic [addr_width-1:0] tail_alias(input logic [addr_width-1:0] a);
      return a + addr_width'(ram_words) *
             addr_width'(1 + $urandom % (int'(ram_decode_limit) / ram_words - 1));
   endfunction

   function automatic logic [addr_width-1:0] io_addr();
      return io_base + addr_width'($urandom % io_regs);
   endfunction

   function automatic logic [addr_width-1:0] undecoded_addr();
      logic [addr_width-1:0] a;
      a = io_base;
      while (a >= io_base && a < io_base + addr_width'(io_regs))
         a = ram_decode_limit +
             addr_width'($urandom % ((1 << addr_width) - int'(ram_decode_limit)));
      return a;
   endfunction

   function automatic logic [addr_width-1:0] any_addr();
      case ($urandom % 4)
         0: return saved[$urandom % n_backed];  // Reuse written words.
         1: return tail_addr();
         2: return io_addr();
         default: return undecoded_addr();
      endcase
   endfunction

   task automatic transfer(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
                           input logic w);
      @(negedge clk);
      start = 1'b1;
      addr = a;
      wdata = d;
      write = w;
      @(negedge clk);
      start = 1'b0;
      addr = addr_width'($urandom);              // Only sampled with start.
      wdata = $urandom;
      while (!done)
         @(negedge clk);
   endtask

   task automatic transfer_with_extra_starts(input logic [addr_width-1:0] a,
                                             input logic [data_width-1:0] d, input logic w);
      @(negedge clk);
      start = 1'b1;
      addr = a;
      wdata = d;
      write = w;
      @(negedge clk);
      while (!done)
      begin
         start = 1'($urandom % 2);
         addr = any_addr();
         wdata = $urandom;
         write = 1'($urandom % 2);
         @(negedge clk);
      end
      start = 1'b0;
   endtask

   task automatic finish_test();
      @(negedge clk);
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
   endtask

   // Each transfer is bounded by the no-response timer.
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("Run hung: no end of test after %0d cycles", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial
   begin
      reset = 1'b1;
      start = 1'b0;
      addr = '0;
      wdata = '0;
      write = 1'b0;
      test_num = 0;
      test_end = 1'b0;
      void'($urandom(32'hf04f));
      repeat (2) @(negedge clk);
      reset = 1'b0;

      test_num = 1;
      for (int i = 0; i < n_backed; i++)
      begin
         saved[i] = backed_addr();
         transfer(saved[i], $urandom, 1'b1);
      end
      for (int i = 0; i < n_backed; i++)
         transfer(saved[n_backed - 1 - i], $urandom, 1'b0);
      finish_test();

      test_num = 2;
      for (int i = 0; i < n_tail; i++)
         transfer(tail_alias(saved[i]), $urandom, 1'b1);
      for (int i = 0; i < n_tail; i++)
         transfer(tail_addr(), $urandom, 1'b0);
      for (int i = 0; i < n_tail; i++)
         transfer(saved[i], $urandom, 1'b0);
      finish_test();

      test_num = 3;
      for (int r = 0; r < io_regs; r++)
      begin
         transfer(io_base + addr_width'(r), $urandom, 1'b1);
         transfer(saved[r], $urandom, 1'b1);
      end
      for (int r = 0; r < io_regs; r++)
      begin
         transfer(io_base + addr_width'(r), $urandom, 1'b0);
         transfer(saved[r], $urandom, 1'b0);
      end
      finish_test();

      test_num = 4;
      for (int i = 0; i < n_undecoded; i++)
         transfer(undecoded_addr(), $urandom, 1'($urandom % 2));
      finish_test();

      test_num = 5;
      for (int i = 0; i < n_dropped; i++)
         transfer_with_extra_starts(any_addr(), $urandom, 1'($urandom % 2));
      finish_test();

      test_num = 6;
      for (int i = 0; i < n_mixed; i++)
         transfer(any_addr(), $urandom, 1'($urandom % 2));
      finish_test();

      @(negedge clk);
      $display("Tests run %0d, failed %0d, errors %0d", n_tests, failed_tests, error_count);
      if (error_count == 0 && failed_tests == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* xbus_top.f */
rtl/xbus_pkg.sv
rtl/xbus_ctrl.sv
rtl/xbus_timer.sv
rtl/xbus_ram.sv
rtl/xbus_io.sv
rtl/xbus_top.sv
verif/xbus_checker.sv
verif/xbus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the bus subsystem testbench with Verilator.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module xbus_tb \
   -f xbus_top.f -o xbus_sim &&
./obj_dir/xbus_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
